/* hdl/div_pkg.sv */
// shared widths, counts and enums for the iterative integer divider
// every divider module pulls these in with a wildcard import

`default_nettype none

package div_pkg;

  // --------------------------------------------------
  // widths and step count
  // --------------------------------------------------

  // operand, quotient and remainder width
  localparam int word_width = 32;

  // one restoring step per quotient bit
  localparam int div_steps = 32;

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------

  // operand, quotient or remainder
  typedef logic [word_width-1:0] word_t;

  // remainder in the upper half, quotient in the lower half
  typedef logic [2*word_width-1:0] result_t;

  // wide enough for div_steps - 1
  typedef logic [$clog2(div_steps)-1:0] step_count_t;

  // --------------------------------------------------
  // enums
  // --------------------------------------------------

  // request function bit
  typedef enum logic [0:0] {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_fn_t;

  // control FSM phases
  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_calc,
    st_sign,
    st_done
  } div_state_t;

endpackage

`default_nettype wire

/* hdl/div_ctrl.sv */
// control FSM for the iterative divider
// runs accept, load, step, sign and respond phases and owns the val/rdy handshake

`default_nettype none

module div_ctrl import div_pkg::*; (
  input  logic clk,
  input  logic reset,

  // request side
  input  logic req_val,
  output logic req_rdy,

  // response side
  output logic resp_val,
  input  logic resp_rdy,

  // from the step counter
  input  logic last_step,

  // datapath strobes
  output logic accept_en,
  output logic load_en,
  output logic step_en,
  output logic sign_en
);

  div_state_t state;
  div_state_t state_next;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // request handshake
        if (req_val) begin
          state_next = st_load;
        end
      end
      st_load: begin
        // datapath and counter load on this edge
        state_next = st_calc;
      end
      st_calc: begin
        // stay until the 32nd step
        if (last_step) begin
          state_next = st_sign;
        end
      end
      st_sign: begin
        // signed result registered on this edge
        state_next = st_done;
      end
      st_done: begin
        // hold result under back-pressure
        if (resp_rdy) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // --------------------------------------------------
  // handshake and strobes, decoded from state
  // --------------------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // capture operands only on a real transfer
  assign accept_en = req_rdy && req_val;
  assign load_en   = (state == st_load);
  assign step_en   = (state == st_calc);
  assign sign_en   = (state == st_sign);

endmodule

`default_nettype wire

/* hdl/div_step_counter.sv */
// counts the shift-subtract steps of one division
// last_step tells the FSM that the current step is the final one

`default_nettype none

module div_step_counter import div_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic load_en,
  input  logic step_en,
  output logic last_step
);

  // index of the final step
  localparam step_count_t last_count = step_count_t'(div_steps - 1);

  step_count_t count;

  // clear on load, bump on each step
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load_en) begin
      count <= '0;
    end else if (step_en) begin
      count <= count + step_count_t'(1);
    end
  end

  // combinational flag, high during step 31
  assign last_step = (count == last_count);

endmodule

`default_nettype wire

/* hdl/div_operand_unsign.sv */
// request register for the divider
// holds fn and operands from the accept edge and presents magnitudes plus sign flags

`default_nettype none

module div_operand_unsign import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    accept_en,
  input  div_fn_t req_fn,
  input  word_t   req_a,
  input  word_t   req_b,
  output div_fn_t fn,
  output logic    sign_a,
  output logic    sign_b,
  output logic    b_zero,
  output word_t   mag_a,
  output word_t   mag_b,
  output word_t   req_a_held
);

  word_t a_q;
  word_t b_q;

  // function bit
  always_ff @(posedge clk) begin
    if (reset) begin
      fn <= div_unsigned;
    end else if (accept_en) begin
      fn <= req_fn;
    end
  end

  // raw operands
  always_ff @(posedge clk) begin
    if (accept_en) begin
      a_q <= req_a;
      b_q <= req_b;
    end
  end

  // top bits count as signs only in signed mode
  assign sign_a = (fn == div_signed) && a_q[word_width-1];
  assign sign_b = (fn == div_signed) && b_q[word_width-1];

  // two's-complement negate the negative ones
  assign mag_a = sign_a ? (~a_q + word_t'(1)) : a_q;
  assign mag_b = sign_b ? (~b_q + word_t'(1)) : b_q;

  assign b_zero     = (b_q == '0);
  // raw dividend, needed for the divide-by-zero remainder
  assign req_a_held = a_q;

endmodule

`default_nettype wire

/* hdl/div_shift_sub.sv */
// restoring shift-subtract datapath
// one load then 32 steps leave quotient and remainder magnitudes on the outputs

`default_nettype none

module div_shift_sub import div_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  load_en,
  input  logic  step_en,
  input  word_t mag_a,
  input  word_t mag_b,
  output word_t quot_mag,
  output word_t rem_mag
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  // partial remainder above, dividend/quotient bits below
  logic [2*word_width:0] rq_q;
  // divisor magnitude, held for the whole division
  word_t                 divisor_q;

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------

  logic [2*word_width:0] rq_shift;
  // 33-bit trial difference, msb is the borrow
  logic [word_width:0]   trial_diff;
  logic                  fits;
  logic [2*word_width:0] rq_step;

  // bring in the next dividend bit
  assign rq_shift = rq_q << 1;

  // upper word_width+1 bits against the divisor
  assign trial_diff = rq_shift[2*word_width:word_width] - {1'b0, divisor_q};

  // no borrow, divisor fits
  assign fits = ~trial_diff[word_width];

  always_comb begin
    if (fits) begin
      // keep the difference, quotient bit set
      rq_step = {trial_diff, rq_shift[word_width-1:1], 1'b1};
    end else begin
      // restore, quotient bit stays 0
      rq_step = rq_shift;
    end
  end

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q <= '0;
    end else if (load_en) begin
      rq_q <= {{(word_width+1){1'b0}}, mag_a};
    end else if (step_en) begin
      rq_q <= rq_step;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      divisor_q <= mag_b;
    end
  end

  // valid after the last step
  assign quot_mag = rq_q[word_width-1:0];
  assign rem_mag  = rq_q[2*word_width-1:word_width];

endmodule

`default_nettype wire

/* hdl/div_result_sign.sv */
// result stage of the divider
// signs the magnitudes, applies the divide-by-zero rule and holds the response

`default_nettype none

module div_result_sign import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    sign_en,
  input  div_fn_t fn,
  input  logic    sign_a,
  input  logic    sign_b,
  input  logic    b_zero,
  input  word_t   quot_mag,
  input  word_t   rem_mag,
  input  word_t   req_a_held,
  output result_t resp_result
);

  logic  neg_quot;
  logic  neg_rem;
  word_t quot_signed;
  word_t rem_signed;
  word_t quot_final;
  word_t rem_final;

  // quotient negative when the signs differ, remainder follows a
  assign neg_quot = (fn == div_signed) && (sign_a ^ sign_b);
  assign neg_rem  = (fn == div_signed) && sign_a;

  assign quot_signed = neg_quot ? (~quot_mag + word_t'(1)) : quot_mag;
  assign rem_signed  = neg_rem ? (~rem_mag + word_t'(1)) : rem_mag;

  // divide by zero, RISC-V style
  assign quot_final = b_zero ? '1 : quot_signed;
  assign rem_final  = b_zero ? req_a_held : rem_signed;

  // stays put through st_done
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_result <= '0;
    end else if (sign_en) begin
      resp_result <= {rem_final, quot_final};
    end
  end

endmodule

`default_nettype wire

/* hdl/int_div_iterative.sv */
// iterative 32-bit integer divider with val/rdy request and response ports
// result is remainder in the upper half and quotient in the lower, 34 cycles after accept

`default_nettype none

module int_div_iterative import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // request
  input  div_fn_t req_fn,
  input  word_t   req_a,
  input  word_t   req_b,
  input  logic    req_val,
  output logic    req_rdy,

  // response
  output result_t resp_result,
  output logic    resp_val,
  input  logic    resp_rdy
);

  // --------------------------------------------------
  // internal wires
  // --------------------------------------------------

  // strobes from control
  logic accept_en;
  logic load_en;
  logic step_en;
  logic sign_en;
  logic last_step;

  // operand stage outputs
  div_fn_t fn;
  logic    sign_a;
  logic    sign_b;
  logic    b_zero;
  word_t   mag_a;
  word_t   mag_b;
  word_t   req_a_held;

  // raw magnitudes out of the datapath
  word_t quot_mag;
  word_t rem_mag;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  div_ctrl i_div_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .last_step (last_step),
    .accept_en (accept_en),
    .load_en   (load_en),
    .step_en   (step_en),
    .sign_en   (sign_en)
  );

  div_step_counter i_div_step_counter (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .step_en   (step_en),
    .last_step (last_step)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  div_operand_unsign i_div_operand_unsign (
    .clk        (clk),
    .reset      (reset),
    .accept_en  (accept_en),
    .req_fn     (req_fn),
    .req_a      (req_a),
    .req_b      (req_b),
    .fn         (fn),
    .sign_a     (sign_a),
    .sign_b     (sign_b),
    .b_zero     (b_zero),
    .mag_a      (mag_a),
    .mag_b      (mag_b),
    .req_a_held (req_a_held)
  );

  div_shift_sub i_div_shift_sub (
    .clk      (clk),
    .reset    (reset),
    .load_en  (load_en),
    .step_en  (step_en),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

  div_result_sign i_div_result_sign (
    .clk         (clk),
    .reset       (reset),
    .sign_en     (sign_en),
    .fn          (fn),
    .sign_a      (sign_a),
    .sign_b      (sign_b),
    .b_zero      (b_zero),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .req_a_held  (req_a_held),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

/* tb/div_checker.sv */
// response checker for the divider testbench
// watches the DUT ports on rising edges, compares responses and timing, counts errors

`default_nettype none

module div_checker import div_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    req_val,
  input  logic    req_rdy,
  input  div_fn_t req_fn,
  input  word_t   req_a,
  input  word_t   req_b,
  input  result_t resp_result,
  input  logic    resp_val,
  input  logic    resp_rdy,
  output int      errors,
  output int      responses
);

  timeunit 1ns;
  timeprecision 1ps;

  // accept edge to resp_val rise
  localparam int latency = 34;

  int      error_count = 0;
  int      response_count = 0;
  int      cycle = 0;
  int      accept_cycle = 0;
  logic    busy = 1'b0;
  div_fn_t held_fn = div_unsigned;
  word_t   held_a = '0;
  word_t   held_b = '0;

  // values seen at the previous edge
  logic    prev_reset = 1'b0;
  logic    prev_val = 1'b0;
  logic    prev_rdy = 1'b0;
  result_t prev_result = '0;

  assign errors    = error_count;
  assign responses = response_count;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, expected);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    error_count++;
  endtask

  // --------------------------------------------------
  // sampling on the rising edge, inputs move on the falling one
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle++;
    // state was reset at the previous edge
    if (prev_reset) begin
      if (resp_val)
        report_mismatch("resp_val", 64'(resp_val), 64'd0);
      if (!req_rdy)
        report_mismatch("req_rdy", 64'(req_rdy), 64'd1);
    end
    if (reset) begin
      busy = 1'b0;
    end else begin
      // request handshake
      if (req_val && req_rdy) begin
        if (busy)
          report_failure("request accepted while a division was in flight");
        busy         = 1'b1;
        accept_cycle = cycle;
        held_fn      = req_fn;
        held_a       = req_a;
        held_b       = req_b;
      end
      // rise happened at the previous edge
      if (resp_val && !prev_val) begin
        if (!busy)
          report_failure("resp_val rose without an accepted request");
        else if (cycle - 1 - accept_cycle != latency)
          report_mismatch("latency", 64'(cycle - 1 - accept_cycle), 64'(latency));
      end
      // no new request while a response waits
      if (resp_val && req_rdy)
        report_mismatch("req_rdy", 64'(req_rdy), 64'd0);
      // back-pressure hold
      if (prev_val && !prev_rdy) begin
        if (!resp_val)
          report_failure("resp_val dropped before the response handshake");
        else if (resp_result != prev_result)
          report_mismatch("resp_result", resp_result, prev_result);
      end
      // idle again one cycle after the response handshake
      if (prev_val && prev_rdy && !req_rdy)
        report_mismatch("req_rdy", 64'(req_rdy), 64'd1);
      // response handshake
      if (resp_val && resp_rdy) begin
        if (response_count >= tb_int_div.exp_q.size()) begin
          report_failure("more responses than tests");
        end else if (resp_result != tb_int_div.exp_q[response_count]) begin
          $display("** Error at %0t: resp_result = 0x%h, expected 0x%h (fn %0d a 0x%h b 0x%h)",
                   $time, resp_result, tb_int_div.exp_q[response_count], held_fn, held_a,
                   held_b);
          error_count++;
        end
        response_count++;
        busy = 1'b0;
      end
    end
    prev_reset  = reset;
    prev_val    = resp_val && !reset;
    prev_rdy    = resp_rdy;
    prev_result = resp_result;
  end

endmodule

`default_nettype wire

/* tb/tb_int_div.sv */
// testbench top for the iterative divider
// reads tb/div_tests.txt, drives requests with random idle gaps and back-pressure,
// div_checker does the comparing

`default_nettype none

module tb_int_div import div_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // worst case per test: latency, idle gap and stall
  localparam int cycles_per_test = 34 + 8 + 8;

  logic    clk;
  logic    reset;
  div_fn_t req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    req_val;
  logic    req_rdy;
  result_t resp_result;
  logic    resp_val;
  logic    resp_rdy;

  // test columns, exp_q is also read by the checker
  logic    fn_q[$];
  word_t   a_q[$];
  word_t   b_q[$];
  result_t exp_q[$];

  logic [31:0] rng;
  logic        tests_loaded;
  int          tb_errors;
  int          errors;
  int          responses;

  int_div_iterative i_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  div_checker i_div_checker (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .errors      (errors),
    .responses   (responses)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // one line per test: fn a b expected
  task automatic load_tests();
    int          fd;
    string       line;
    logic [31:0] f_fn;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [63:0] f_exp;
    fd = $fopen("tb/div_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tb/div_tests.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        // comment and blank lines yield no fields
        if ($fgets(line, fd) != 0) begin
          if ($sscanf(line, "%h %h %h %h", f_fn, f_a, f_b, f_exp) == 4) begin
            fn_q.push_back(f_fn[0]);
            a_q.push_back(f_a);
            b_q.push_back(f_b);
            exp_q.push_back(f_exp);
          end
        end
      end
      $fclose(fd);
    end
    if (exp_q.size() == 0) begin
      $display("error: no tests were read from tb/div_tests.txt");
      tb_errors++;
    end
  endtask

  // one request and its response, entered and left on a falling edge
  task automatic run_test(input int idx);
    logic [2:0] gap;
    logic [2:0] stall;
    rng = xorshift32(rng);
    gap = rng[2:0];
    rng = xorshift32(rng);
    stall = rng[6:4];
    repeat (gap) @(negedge clk);
    req_fn  = div_fn_t'(fn_q[idx]);
    req_a   = a_q[idx];
    req_b   = b_q[idx];
    req_val = 1'b1;
    // req_rdy is settled at the falling edge, so the next rising edge accepts
    while (!req_rdy) @(negedge clk);
    @(negedge clk);
    // request stays pending with scrambled operands
    // the DUT must neither take it nor lose its own copy
    req_a = rng;
    req_b = ~rng;
    while (!resp_val) @(negedge clk);
    // back-pressure stretch
    repeat (stall) @(negedge clk);
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    int total;
    reset        = 1'b1;
    req_fn       = div_unsigned;
    req_a        = '0;
    req_b        = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    rng          = 32'habeb;
    tb_errors    = 0;
    tests_loaded = 1'b0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < exp_q.size(); i++) begin
      run_test(i);
    end
    repeat (4) @(negedge clk);
    if (responses != exp_q.size()) begin
      $display("error: %0d responses seen for %0d tests", responses, exp_q.size());
      tb_errors++;
    end
    total = errors + tb_errors;
    $display("tests %0d, responses %0d, errors %0d", exp_q.size(), responses, total);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog, sized from the number of tests
  initial begin
    int limit;
    wait (tests_loaded === 1'b1);
    limit = exp_q.size() * cycles_per_test + 20;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/div_tests.txt */
// columns: fn (0 unsigned, 1 signed), a, b, expected {remainder, quotient}
// all values in hex
0 00000064 00000007 000000020000000e
0 00000005 0000000a 0000000500000000
0 12345678 12345678 0000000000000001
0 ffffffff 00000001 00000000ffffffff
0 ffffffff 00000010 0000000f0fffffff
0 80000000 00000003 000000022aaaaaaa
0 deadbeef 00001000 00000eef000deadb
0 00000000 00000005 0000000000000000
0 fffffffe ffffffff fffffffe00000000
0 80000000 ffffffff 8000000000000000
0 0000ffff 00000100 000000ff000000ff
// signed, all four sign combinations
1 00000064 00000007 000000020000000e
1 ffffff9c 00000007 fffffffefffffff2
1 00000064 fffffff9 00000002fffffff2
1 ffffff9c fffffff9 fffffffe0000000e
1 fffffff9 00000064 fffffff900000000
1 7fffffff ffffffff 0000000080000001
1 80000000 00000002 00000000c0000000
1 80000000 00000007 fffffffeedb6db6e
1 00000000 ffffffff 0000000000000000
// divide by zero and overflow
0 12345678 00000000 12345678ffffffff
1 87654321 00000000 87654321ffffffff
0 00000000 00000000 00000000ffffffff
1 80000000 ffffffff 0000000080000000

/* sim.f */
hdl/div_pkg.sv
hdl/div_ctrl.sv
hdl/div_step_counter.sv
hdl/div_operand_unsign.sv
hdl/div_shift_sub.sv
hdl/div_result_sign.sv
hdl/int_div_iterative.sv
tb/div_checker.sv
tb/tb_int_div.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_int_div -f sim.f

output="$(./obj_dir/Vtb_int_div)"
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
